//--- design/mem_pkg.sv
package mem_pkg;

  // one memory word holds one register
  parameter int DATA_W = 32;

  // word address space of the shared memory
  parameter int ADDR_W = 8;
  parameter int MEM_WORDS = 1 << ADDR_W;

  // register numbering inside the memory window
  parameter int REG_NUM_W = 4;
  // instruction pointer lives in the last register
  parameter logic [REG_NUM_W-1:0] REG_IP = 4'd15;

  // one register manager per operand slot
  parameter int NUM_SLOTS = 5;

  // slot indices, listed in write-back order
  typedef enum logic [2:0] {
    SLOT_IP,
    SLOT_DST,
    SLOT_COND,
    SLOT_SRC1,
    SLOT_SRC0
  } slot_e;

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

  // full 4-bit opcode space, decoded by the alu side only
  typedef enum logic [3:0] {
    OP_NOP, OP_MOV, OP_ADD, OP_SUB,
    OP_AND, OP_OR,  OP_XOR, OP_NOT,
    OP_SHL, OP_SHR, OP_MUL, OP_CMP,
    OP_JMP, OP_INC, OP_DEC, OP_HALT
  } opcode_e;

  // post-modification of a register after use
  typedef enum logic [1:0] {
    IDX_NONE = 2'b00,
    IDX_INC  = 2'b01,
    IDX_DEC  = 2'b10,
    IDX_KEEP = 2'b11
  } idx_mode_e;

  // command word, msb first, src1 register in the low nibble
  typedef struct packed {
    opcode_e                       opcode;
    idx_mode_e                     cond_mode;
    idx_mode_e                     dst_mode;
    idx_mode_e                     src0_mode;
    idx_mode_e                     src1_mode;
    logic                          cond_ptr;
    logic                          dst_ptr;
    logic                          src0_ptr;
    logic                          src1_ptr;
    logic [mem_pkg::REG_NUM_W-1:0] cond_reg;
    logic [mem_pkg::REG_NUM_W-1:0] dst_reg;
    logic [mem_pkg::REG_NUM_W-1:0] src0_reg;
    logic [mem_pkg::REG_NUM_W-1:0] src1_reg;
  } cmd_word_t;

  // dispatcher steps of one instruction, in issue order
  typedef enum logic [3:0] {
    STEP_IDLE,
    STEP_FETCH,
    STEP_READ_COND,
    STEP_READ_SRC1,
    STEP_READ_SRC0,
    STEP_READ_DST,
    STEP_WRITE_IP,
    STEP_WRITE_DST,
    STEP_WRITE_COND,
    STEP_WRITE_SRC1,
    STEP_WRITE_SRC0
  } step_e;

  // per-slot command derived from the step
  typedef enum logic [1:0] {
    SLOT_NULL,
    SLOT_READ,
    SLOT_WRITE
  } slot_op_e;

endpackage

//--- design/slot_bus_if.sv
`timescale 1ns/1ps

interface slot_bus_if #(
  parameter int DATA_W = mem_pkg::DATA_W,
  parameter int ADDR_W = mem_pkg::ADDR_W
);

  // request side, owned by the slot
  // levels held until the matching done pulse
  logic              read_q;
  logic              write_q;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;

  // answer side, owned by the mux
  logic [DATA_W-1:0] rdata;
  logic              read_dn;
  logic              write_dn;

  modport requester (
    output read_q, write_q, addr, wdata,
    input  rdata, read_dn, write_dn
  );

  modport server (
    input  read_q, write_q, addr, wdata,
    output rdata, read_dn, write_dn
  );

endinterface

//--- design/step_decoder.sv
`timescale 1ns/1ps

module step_decoder (
  input  isa_pkg::step_e    step,
  output isa_pkg::slot_op_e slot_op [mem_pkg::NUM_SLOTS]
);

  // one slot active per step, the rest idle
  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_SLOTS; i++) begin
      slot_op[i] = isa_pkg::SLOT_NULL;
    end
    case (step)
      // fetch is the ip slot reading through its pointer
      isa_pkg::STEP_FETCH: begin
        slot_op[mem_pkg::SLOT_IP] = isa_pkg::SLOT_READ;
      end
      isa_pkg::STEP_READ_COND: begin
        slot_op[mem_pkg::SLOT_COND] = isa_pkg::SLOT_READ;
      end
      isa_pkg::STEP_READ_SRC1: begin
        slot_op[mem_pkg::SLOT_SRC1] = isa_pkg::SLOT_READ;
      end
      isa_pkg::STEP_READ_SRC0: begin
        slot_op[mem_pkg::SLOT_SRC0] = isa_pkg::SLOT_READ;
      end
      isa_pkg::STEP_READ_DST: begin
        slot_op[mem_pkg::SLOT_DST] = isa_pkg::SLOT_READ;
      end
      // write-back steps, ip first
      isa_pkg::STEP_WRITE_IP: begin
        slot_op[mem_pkg::SLOT_IP] = isa_pkg::SLOT_WRITE;
      end
      isa_pkg::STEP_WRITE_DST: begin
        slot_op[mem_pkg::SLOT_DST] = isa_pkg::SLOT_WRITE;
      end
      isa_pkg::STEP_WRITE_COND: begin
        slot_op[mem_pkg::SLOT_COND] = isa_pkg::SLOT_WRITE;
      end
      isa_pkg::STEP_WRITE_SRC1: begin
        slot_op[mem_pkg::SLOT_SRC1] = isa_pkg::SLOT_WRITE;
      end
      isa_pkg::STEP_WRITE_SRC0: begin
        slot_op[mem_pkg::SLOT_SRC0] = isa_pkg::SLOT_WRITE;
      end
      default: ;
    endcase
  end

  // dispatcher only ever presents a defined step code
  always_comb begin
    assert final (!$isunknown(step) && step <= isa_pkg::STEP_WRITE_SRC0)
      else $error("step_decoder: undefined step code %0h", step);
  end

endmodule

//--- design/save_policy.sv
`timescale 1ns/1ps

module save_policy (
  input  isa_pkg::cmd_word_t            cmd,
  output logic [mem_pkg::NUM_SLOTS-1:0] save_ok
);

  // slot changes its register this instruction
  logic [mem_pkg::NUM_SLOTS-1:0] modifies;
  // register each slot would write back
  logic [mem_pkg::REG_NUM_W-1:0] reg_num [mem_pkg::NUM_SLOTS];

  function automatic logic is_step(isa_pkg::idx_mode_e mode);
    return (mode == isa_pkg::IDX_INC) || (mode == isa_pkg::IDX_DEC);
  endfunction

  assign reg_num[mem_pkg::SLOT_IP]   = mem_pkg::REG_IP;
  assign reg_num[mem_pkg::SLOT_DST]  = cmd.dst_reg;
  assign reg_num[mem_pkg::SLOT_COND] = cmd.cond_reg;
  assign reg_num[mem_pkg::SLOT_SRC1] = cmd.src1_reg;
  assign reg_num[mem_pkg::SLOT_SRC0] = cmd.src0_reg;

  // ip always post-increments
  assign modifies[mem_pkg::SLOT_IP]   = 1'b1;
  // direct dst takes the result, pointer dst only steps the pointer
  assign modifies[mem_pkg::SLOT_DST]  = !cmd.dst_ptr || is_step(cmd.dst_mode);
  assign modifies[mem_pkg::SLOT_COND] = is_step(cmd.cond_mode);
  assign modifies[mem_pkg::SLOT_SRC1] = is_step(cmd.src1_mode);
  assign modifies[mem_pkg::SLOT_SRC0] = is_step(cmd.src0_mode);

  // last writer of a register wins, earlier ones are dropped
  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_SLOTS; i++) begin
      save_ok[i] = modifies[i];
      for (int j = i + 1; j < mem_pkg::NUM_SLOTS; j++) begin
        if (modifies[j] && (reg_num[j] == reg_num[i])) begin
          save_ok[i] = 1'b0;
        end
      end
    end
  end

endmodule

//--- design/operand_slot.sv
`timescale 1ns/1ps

module operand_slot #(
  parameter int DATA_W = mem_pkg::DATA_W,
  parameter int ADDR_W = mem_pkg::ADDR_W,
  parameter bit IS_DST = 1'b0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  isa_pkg::slot_op_e             op,
  input  logic [ADDR_W-1:0]             base_addr,
  input  logic [mem_pkg::REG_NUM_W-1:0] reg_num,
  input  logic                          is_ptr,
  input  isa_pkg::idx_mode_e            idx_mode,
  input  logic                          save_ok,
  input  logic [DATA_W-1:0]             alu_result,
  slot_bus_if.requester                 bus,
  output logic [DATA_W-1:0]             operand,
  output logic                          done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_REG,
    S_RD_PTR,
    S_WR_DATA,
    S_WR_IDX,
    S_FIN,
    S_WAIT
  } state_e;

  state_e            state;
  // register contents as read in this instruction
  logic [DATA_W-1:0] reg_val;
  logic [ADDR_W-1:0] reg_addr;
  logic [ADDR_W-1:0] ptr_addr;
  logic [DATA_W-1:0] idx_val;
  logic              rd_ack;
  logic              wr_ack;

  // register n sits at base_addr + n
  assign reg_addr = base_addr + ADDR_W'(reg_num);
  // pointer target is the low part of the register
  assign ptr_addr = reg_val[ADDR_W-1:0];
  assign idx_val  = (idx_mode == isa_pkg::IDX_DEC) ? reg_val - DATA_W'(1)
                                                    : reg_val + DATA_W'(1);

  assign rd_ack = bus.read_q && bus.read_dn;
  assign wr_ack = bus.write_q && bus.write_dn;

  // address and data follow the access in progress
  always_comb begin
    bus.addr  = reg_addr;
    bus.wdata = idx_val;
    case (state)
      S_RD_PTR: begin
        bus.addr = ptr_addr;
      end
      S_WR_DATA: begin
        bus.addr  = is_ptr ? ptr_addr : reg_addr;
        bus.wdata = alu_result;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      bus.read_q  <= 1'b0;
      bus.write_q <= 1'b0;
      operand     <= '0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (op == isa_pkg::SLOT_READ) begin
            state <= S_RD_REG;
          end else if (op == isa_pkg::SLOT_WRITE) begin
            // dst always touches memory when it has a pointer target
            if (IS_DST && (is_ptr || save_ok)) begin
              state <= S_WR_DATA;
            end else if (!IS_DST && save_ok) begin
              state <= S_WR_IDX;
            end else begin
              state <= S_FIN;
            end
          end
        end
        S_RD_REG: begin
          if (!bus.read_q) begin
            bus.read_q <= 1'b1;
          end else if (rd_ack) begin
            bus.read_q <= 1'b0;
            operand    <= bus.rdata;
            state      <= is_ptr ? S_RD_PTR : S_FIN;
          end
        end
        S_RD_PTR: begin
          // second read replaces the register value as operand
          if (!bus.read_q) begin
            bus.read_q <= 1'b1;
          end else if (rd_ack) begin
            bus.read_q <= 1'b0;
            operand    <= bus.rdata;
            state      <= S_FIN;
          end
        end
        S_WR_DATA: begin
          if (!bus.write_q) begin
            bus.write_q <= 1'b1;
          end else if (wr_ack) begin
            bus.write_q <= 1'b0;
            // pointer dst may still step its pointer register
            state       <= (is_ptr && save_ok) ? S_WR_IDX : S_FIN;
          end
        end
        S_WR_IDX: begin
          if (!bus.write_q) begin
            bus.write_q <= 1'b1;
          end else if (wr_ack) begin
            bus.write_q <= 1'b0;
            state       <= S_FIN;
          end
        end
        S_FIN: begin
          done  <= 1'b1;
          state <= S_WAIT;
        end
        // hold until the dispatcher moves on
        S_WAIT: begin
          if (op == isa_pkg::SLOT_NULL) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // register value captured on the first read only
  always_ff @(posedge clk) begin
    if ((state == S_RD_REG) && rd_ack) begin
      reg_val <= bus.rdata;
    end
  end

  // never a read and a write from one slot at once
  assert property (@(posedge clk) disable iff (rst) !(bus.read_q && bus.write_q))
    else $error("operand_slot: read_q and write_q high together");

  // pending read holds until memory answers
  assert property (@(posedge clk) disable iff (rst)
    (bus.read_q && !bus.read_dn) |=> bus.read_q)
    else $error("operand_slot: read_q dropped before read_dn");

endmodule

//--- design/bus_mux.sv
`timescale 1ns/1ps

module bus_mux #(
  parameter int DATA_W = mem_pkg::DATA_W,
  parameter int ADDR_W = mem_pkg::ADDR_W
) (
  slot_bus_if.server        slots [mem_pkg::NUM_SLOTS],
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  output logic              read_q,
  output logic              write_q,
  input  logic [DATA_W-1:0] mem_rdata,
  input  logic              read_dn,
  input  logic              write_dn
);

  logic [mem_pkg::NUM_SLOTS-1:0] rd_req;
  logic [mem_pkg::NUM_SLOTS-1:0] wr_req;
  // per-slot terms, zero unless that slot requests
  logic [ADDR_W-1:0]             addr_term  [mem_pkg::NUM_SLOTS];
  logic [DATA_W-1:0]             wdata_term [mem_pkg::NUM_SLOTS];

  for (genvar i = 0; i < mem_pkg::NUM_SLOTS; i++) begin : g_slot
    logic req;
    assign rd_req[i]     = slots[i].read_q;
    assign wr_req[i]     = slots[i].write_q;
    assign req           = rd_req[i] | wr_req[i];
    assign addr_term[i]  = {ADDR_W{req}} & slots[i].addr;
    assign wdata_term[i] = {DATA_W{wr_req[i]}} & slots[i].wdata;
    // read data fans out, done pulses only to the owner
    assign slots[i].rdata    = mem_rdata;
    assign slots[i].read_dn  = read_dn & rd_req[i];
    assign slots[i].write_dn = write_dn & wr_req[i];
  end

  // and-or select, one requester at most
  always_comb begin
    mem_addr  = '0;
    mem_wdata = '0;
    for (int i = 0; i < mem_pkg::NUM_SLOTS; i++) begin
      mem_addr  = mem_addr | addr_term[i];
      mem_wdata = mem_wdata | wdata_term[i];
    end
  end

  assign read_q  = |rd_req;
  assign write_q = |wr_req;

  // steps are serialized, so slots never overlap on the bus
  always_comb begin
    assert final ($isunknown(rd_req | wr_req) || $onehot0(rd_req | wr_req))
      else $error("bus_mux: several slots request at once (%b/%b)", rd_req, wr_req);
  end

endmodule

//--- design/mem_manager.sv
`timescale 1ns/1ps

module mem_manager #(
  parameter int DATA_W = mem_pkg::DATA_W,
  parameter int ADDR_W = mem_pkg::ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  input  isa_pkg::step_e     step,
  input  logic [ADDR_W-1:0]  base_addr,
  input  logic [DATA_W-1:0]  alu_result,
  input  logic [DATA_W-1:0]  mem_rdata,
  input  logic               read_dn,
  input  logic               write_dn,
  output logic [ADDR_W-1:0]  mem_addr,
  output logic [DATA_W-1:0]  mem_wdata,
  output logic               read_q,
  output logic               write_q,
  output logic               step_done,
  output isa_pkg::cmd_word_t command_word,
  output isa_pkg::opcode_e   opcode,
  output logic [DATA_W-1:0]  cond,
  output logic [DATA_W-1:0]  src1,
  output logic [DATA_W-1:0]  src0
);

  isa_pkg::slot_op_e             slot_op   [mem_pkg::NUM_SLOTS];
  logic [mem_pkg::NUM_SLOTS-1:0] save_ok;
  logic [mem_pkg::NUM_SLOTS-1:0] slot_done;
  logic [DATA_W-1:0]             operand   [mem_pkg::NUM_SLOTS];
  logic [mem_pkg::REG_NUM_W-1:0] reg_num   [mem_pkg::NUM_SLOTS];
  logic [mem_pkg::NUM_SLOTS-1:0] is_ptr;
  isa_pkg::idx_mode_e            idx_mode  [mem_pkg::NUM_SLOTS];

  slot_bus_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) slot_bus [mem_pkg::NUM_SLOTS] ();

  // fetched word comes out of the ip slot
  assign command_word = operand[mem_pkg::SLOT_IP];
  assign opcode       = command_word.opcode;
  assign cond         = operand[mem_pkg::SLOT_COND];
  assign src1         = operand[mem_pkg::SLOT_SRC1];
  assign src0         = operand[mem_pkg::SLOT_SRC0];

  // ip reads through itself and post-increments
  assign reg_num[mem_pkg::SLOT_IP]   = mem_pkg::REG_IP;
  assign is_ptr[mem_pkg::SLOT_IP]    = 1'b1;
  assign idx_mode[mem_pkg::SLOT_IP]  = isa_pkg::IDX_INC;
  // remaining slots from the command fields
  assign reg_num[mem_pkg::SLOT_DST]  = command_word.dst_reg;
  assign is_ptr[mem_pkg::SLOT_DST]   = command_word.dst_ptr;
  assign idx_mode[mem_pkg::SLOT_DST] = command_word.dst_mode;
  assign reg_num[mem_pkg::SLOT_COND]  = command_word.cond_reg;
  assign is_ptr[mem_pkg::SLOT_COND]   = command_word.cond_ptr;
  assign idx_mode[mem_pkg::SLOT_COND] = command_word.cond_mode;
  assign reg_num[mem_pkg::SLOT_SRC1]  = command_word.src1_reg;
  assign is_ptr[mem_pkg::SLOT_SRC1]   = command_word.src1_ptr;
  assign idx_mode[mem_pkg::SLOT_SRC1] = command_word.src1_mode;
  assign reg_num[mem_pkg::SLOT_SRC0]  = command_word.src0_reg;
  assign is_ptr[mem_pkg::SLOT_SRC0]   = command_word.src0_ptr;
  assign idx_mode[mem_pkg::SLOT_SRC0] = command_word.src0_mode;

  // only one slot finishes per step
  assign step_done = |slot_done;

  step_decoder u_step_decoder (
    .step    (step),
    .slot_op (slot_op)
  );

  save_policy u_save_policy (
    .cmd     (command_word),
    .save_ok (save_ok)
  );

  for (genvar i = 0; i < mem_pkg::NUM_SLOTS; i++) begin : g_slot
    operand_slot #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W),
      .IS_DST (i == mem_pkg::SLOT_DST)
    ) u_slot (
      .clk        (clk),
      .rst        (rst),
      .op         (slot_op[i]),
      .base_addr  (base_addr),
      .reg_num    (reg_num[i]),
      .is_ptr     (is_ptr[i]),
      .idx_mode   (idx_mode[i]),
      .save_ok    (save_ok[i]),
      .alu_result ((i == mem_pkg::SLOT_DST) ? alu_result : {DATA_W{1'b0}}),
      .bus        (slot_bus[i]),
      .operand    (operand[i]),
      .done       (slot_done[i])
    );
  end

  bus_mux #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_bus_mux (
    .slots     (slot_bus),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .read_q    (read_q),
    .write_q   (write_q),
    .mem_rdata (mem_rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn)
  );

endmodule

//--- verif/tb_mem_manager.sv
`timescale 1ns/1ps

module tb_mem_manager;

  localparam int DW              = mem_pkg::DATA_W;
  localparam int AW              = mem_pkg::ADDR_W;
  localparam int NS              = mem_pkg::NUM_SLOTS;
  localparam int MEM_WORDS       = mem_pkg::MEM_WORDS;
  localparam int NUM_TESTS       = 4;
  localparam int INSTR_PER_TEST  = 10;
  localparam int STEPS_PER_INSTR = 10;
  // ten cycles per step, doubled
  localparam int TIMEOUT_CYCLES  = NUM_TESTS * INSTR_PER_TEST * STEPS_PER_INSTR * 10 * 2;

  logic               clk;
  logic               rst;
  isa_pkg::step_e     step;
  logic [AW-1:0]      base_addr;
  logic [DW-1:0]      alu_result;
  logic [DW-1:0]      mem_rdata;
  logic               read_dn;
  logic               write_dn;
  logic [AW-1:0]      mem_addr;
  logic [DW-1:0]      mem_wdata;
  logic               read_q;
  logic               write_q;
  logic               step_done;
  isa_pkg::cmd_word_t command_word;
  isa_pkg::opcode_e   opcode;
  logic [DW-1:0]      cond;
  logic [DW-1:0]      src1;
  logic [DW-1:0]      src0;

  // memory seen by the DUT, and the model's own copy
  logic [DW-1:0]      mem     [MEM_WORDS];
  logic [DW-1:0]      ref_mem [MEM_WORDS];

  // per-slot model state for the current instruction
  logic [mem_pkg::REG_NUM_W-1:0] m_reg    [NS];
  logic                          m_ptr    [NS];
  isa_pkg::idx_mode_e            m_mode   [NS];
  logic [DW-1:0]                 m_val    [NS];
  logic [DW-1:0]                 m_opnd   [NS];
  logic                          m_save   [NS];
  int                            m_writes [NS];
  isa_pkg::cmd_word_t            exp_cmd;

  logic [31:0] lfsr;
  logic [31:0] dly_lfsr;
  int          errors;
  int          writes_seen;
  int          done_pulses;
  int          cycle_count;
  // memory responder state
  bit          pending;
  logic [1:0]  wait_cnt;

  mem_manager #(
    .DATA_W (DW),
    .ADDR_W (AW)
  ) u_mem_manager (
    .clk          (clk),
    .rst          (rst),
    .step         (step),
    .base_addr    (base_addr),
    .alu_result   (alu_result),
    .mem_rdata    (mem_rdata),
    .read_dn      (read_dn),
    .write_dn     (write_dn),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .read_q       (read_q),
    .write_q      (write_q),
    .step_done    (step_done),
    .command_word (command_word),
    .opcode       (opcode),
    .cond         (cond),
    .src1         (src1),
    .src0         (src0)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // right-shift galois form, one output bit per step
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hb4bc_d35c;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
    return v;
  endfunction

  // separate stream so responder draws never shift the stimulus
  function automatic logic [1:0] rand_delay();
    logic [1:0] v;
    v = '0;
    for (int i = 0; i < 2; i++) begin
      v        = {v[0], dly_lfsr[0]};
      dly_lfsr = galois_step(dly_lfsr);
    end
    return v;
  endfunction

  function automatic bit changes_reg(input isa_pkg::idx_mode_e mode);
    return (mode == isa_pkg::IDX_INC) || (mode == isa_pkg::IDX_DEC);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // memory responder, 0..3 cycles before each done pulse
  always @(negedge clk) begin
    read_dn  = 1'b0;
    write_dn = 1'b0;
    if (rst || (!read_q && !write_q)) begin
      pending = 1'b0;
    end else begin
      if (!pending) begin
        pending  = 1'b1;
        wait_cnt = rand_delay();
      end
      if (wait_cnt == 2'd0) begin
        if (read_q) begin
          read_dn   = 1'b1;
          mem_rdata = mem[mem_addr];
        end else begin
          write_dn      = 1'b1;
          mem[mem_addr] = mem_wdata;
          writes_seen++;
        end
        pending = 1'b0;
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && step_done) begin
      done_pulses++;
    end
  end

  // hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a step never finished", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // random words everywhere, ip aimed at a random command region
  task automatic load_memory();
    logic [AW-1:0] start;
    base_addr = AW'(rand_bits(AW));
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = rand_bits(DW);
    end
    start = AW'(rand_bits(AW));
    mem[AW'(base_addr + AW'(mem_pkg::REG_IP))] = DW'(start);
    for (int a = 0; a < MEM_WORDS; a++) begin
      ref_mem[a] = mem[a];
    end
  endtask

  task automatic reset_dut();
    rst  = 1'b1;
    step = isa_pkg::STEP_IDLE;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (read_q !== 1'b0) report_mismatch("read_q", 0, read_q);
    if (write_q !== 1'b0) report_mismatch("write_q", 0, write_q);
    if (step_done !== 1'b0) report_mismatch("step_done", 0, step_done);
    if (command_word !== '0) report_mismatch("command_word", 0, command_word);
    if (cond !== '0) report_mismatch("cond", 0, cond);
    if (src1 !== '0) report_mismatch("src1", 0, src1);
    if (src0 !== '0) report_mismatch("src0", 0, src0);
  endtask

  // all reads of one instruction see memory before any write-back
  task automatic decode_instruction();
    logic [AW-1:0] ip_addr;
    logic [AW-1:0] raddr;
    logic          modifies [NS];
    ip_addr = base_addr + AW'(mem_pkg::REG_IP);
    exp_cmd = ref_mem[ref_mem[ip_addr][AW-1:0]];
    m_reg[mem_pkg::SLOT_IP]    = mem_pkg::REG_IP;
    m_ptr[mem_pkg::SLOT_IP]    = 1'b1;
    m_mode[mem_pkg::SLOT_IP]   = isa_pkg::IDX_INC;
    m_reg[mem_pkg::SLOT_DST]   = exp_cmd.dst_reg;
    m_ptr[mem_pkg::SLOT_DST]   = exp_cmd.dst_ptr;
    m_mode[mem_pkg::SLOT_DST]  = exp_cmd.dst_mode;
    m_reg[mem_pkg::SLOT_COND]  = exp_cmd.cond_reg;
    m_ptr[mem_pkg::SLOT_COND]  = exp_cmd.cond_ptr;
    m_mode[mem_pkg::SLOT_COND] = exp_cmd.cond_mode;
    m_reg[mem_pkg::SLOT_SRC1]  = exp_cmd.src1_reg;
    m_ptr[mem_pkg::SLOT_SRC1]  = exp_cmd.src1_ptr;
    m_mode[mem_pkg::SLOT_SRC1] = exp_cmd.src1_mode;
    m_reg[mem_pkg::SLOT_SRC0]  = exp_cmd.src0_reg;
    m_ptr[mem_pkg::SLOT_SRC0]  = exp_cmd.src0_ptr;
    m_mode[mem_pkg::SLOT_SRC0] = exp_cmd.src0_mode;
    for (int s = 0; s < NS; s++) begin
      raddr     = base_addr + AW'(m_reg[s]);
      m_val[s]  = ref_mem[raddr];
      m_opnd[s] = m_ptr[s] ? ref_mem[m_val[s][AW-1:0]] : m_val[s];
      modifies[s] = changes_reg(m_mode[s]);
    end
    modifies[mem_pkg::SLOT_IP]  = 1'b1;
    modifies[mem_pkg::SLOT_DST] = !m_ptr[mem_pkg::SLOT_DST] || modifies[mem_pkg::SLOT_DST];
    // a later writer of the same register cancels an earlier one
    for (int i = 0; i < NS; i++) begin
      m_save[i] = modifies[i];
      for (int j = i + 1; j < NS; j++) begin
        if (modifies[j] && (m_reg[j] == m_reg[i])) begin
          m_save[i] = 1'b0;
        end
      end
      m_writes[i] = int'(m_save[i]);
    end
    // pointer dst always stores its result
    if (m_ptr[mem_pkg::SLOT_DST]) begin
      m_writes[mem_pkg::SLOT_DST]++;
    end
  endtask

  task automatic model_write(input int s);
    logic [AW-1:0] raddr;
    logic [DW-1:0] stepped;
    raddr   = base_addr + AW'(m_reg[s]);
    stepped = (m_mode[s] == isa_pkg::IDX_DEC) ? m_val[s] - 1 : m_val[s] + 1;
    if ((s == mem_pkg::SLOT_DST) && m_ptr[s]) begin
      ref_mem[m_val[s][AW-1:0]] = alu_result;
      if (m_save[s]) ref_mem[raddr] = stepped;
    end else if (s == mem_pkg::SLOT_DST) begin
      if (m_save[s]) ref_mem[raddr] = alu_result;
    end else if (m_save[s]) begin
      ref_mem[raddr] = stepped;
    end
  endtask

  // present one step and wait for its done pulse
  task automatic apply_step(input isa_pkg::step_e s, input bit no_access);
    int cycles;
    bit seen;
    step   = s;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk);
      cycles++;
      seen = step_done;
    end
    if (cycles < 2) report_failure($sformatf("step %s ended too early", s.name()));
    if (no_access && (cycles != 2)) begin
      report_failure($sformatf("step %s without access took %0d cycles", s.name(), cycles));
    end
  endtask

  task automatic run_instruction();
    int            writes_before;
    int            exp_writes;
    logic [AW-1:0] target;
    decode_instruction();
    alu_result    = DW'(rand_bits(DW));
    writes_before = writes_seen;
    apply_step(isa_pkg::STEP_FETCH, 1'b0);
    if (command_word !== exp_cmd) report_mismatch("command_word", exp_cmd, command_word);
    if (opcode !== exp_cmd.opcode) report_mismatch("opcode", exp_cmd.opcode, opcode);
    apply_step(isa_pkg::STEP_READ_COND, 1'b0);
    if (cond !== m_opnd[mem_pkg::SLOT_COND]) report_mismatch("cond", m_opnd[2], cond);
    apply_step(isa_pkg::STEP_READ_SRC1, 1'b0);
    if (src1 !== m_opnd[mem_pkg::SLOT_SRC1]) report_mismatch("src1", m_opnd[3], src1);
    apply_step(isa_pkg::STEP_READ_SRC0, 1'b0);
    if (src0 !== m_opnd[mem_pkg::SLOT_SRC0]) report_mismatch("src0", m_opnd[4], src0);
    apply_step(isa_pkg::STEP_READ_DST, 1'b0);
    // write-back in slot order, model follows each step
    apply_step(isa_pkg::STEP_WRITE_IP, m_writes[mem_pkg::SLOT_IP] == 0);
    model_write(mem_pkg::SLOT_IP);
    apply_step(isa_pkg::STEP_WRITE_DST, m_writes[mem_pkg::SLOT_DST] == 0);
    model_write(mem_pkg::SLOT_DST);
    if (m_writes[mem_pkg::SLOT_DST] != 0) begin
      target = m_ptr[mem_pkg::SLOT_DST] ? m_val[mem_pkg::SLOT_DST][AW-1:0]
                                        : base_addr + AW'(m_reg[mem_pkg::SLOT_DST]);
      if (mem[target] !== ref_mem[target]) begin
        report_mismatch("mem[dst target]", ref_mem[target], mem[target]);
      end
    end
    apply_step(isa_pkg::STEP_WRITE_COND, m_writes[mem_pkg::SLOT_COND] == 0);
    model_write(mem_pkg::SLOT_COND);
    apply_step(isa_pkg::STEP_WRITE_SRC1, m_writes[mem_pkg::SLOT_SRC1] == 0);
    model_write(mem_pkg::SLOT_SRC1);
    apply_step(isa_pkg::STEP_WRITE_SRC0, m_writes[mem_pkg::SLOT_SRC0] == 0);
    model_write(mem_pkg::SLOT_SRC0);
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem[a] !== ref_mem[a]) report_mismatch($sformatf("mem[%0d]", a), ref_mem[a], mem[a]);
    end
    exp_writes = 0;
    for (int s = 0; s < NS; s++) begin
      exp_writes += m_writes[s];
    end
    if (writes_seen - writes_before != exp_writes) begin
      report_mismatch("write count", exp_writes, writes_seen - writes_before);
    end
  endtask

  initial begin
    int errors_before;
    int pulses_before;
    rst         = 1'b1;
    step        = isa_pkg::STEP_IDLE;
    base_addr   = '0;
    alu_result  = '0;
    mem_rdata   = '0;
    read_dn     = 1'b0;
    write_dn    = 1'b0;
    errors      = 0;
    writes_seen = 0;
    done_pulses = 0;
    cycle_count = 0;
    pending     = 1'b0;
    wait_cnt    = '0;
    lfsr        = 32'he1d7_8497;
    // delay stream branched off the main sequence
    dly_lfsr    = rand_bits(32) | 32'h1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      errors_before = errors;
      load_memory();
      reset_dut();
      pulses_before = done_pulses;
      for (int i = 0; i < INSTR_PER_TEST; i++) begin
        run_instruction();
      end
      step = isa_pkg::STEP_IDLE;
      @(negedge clk);
      if (step_done !== 1'b0) report_failure("step_done longer than one cycle");
      if (done_pulses - pulses_before != INSTR_PER_TEST * STEPS_PER_INSTR) begin
        report_mismatch("step_done pulses", INSTR_PER_TEST * STEPS_PER_INSTR,
                        done_pulses - pulses_before);
      end
      $display("test %0d: base_addr %h, %0d instructions, %0d errors", t, base_addr,
               INSTR_PER_TEST, errors - errors_before);
    end
    $display("tests %0d, instructions %0d, writes %0d, errors %0d", NUM_TESTS,
             NUM_TESTS * INSTR_PER_TEST, writes_seen, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mem_manager.f
design/mem_pkg.sv
design/isa_pkg.sv
design/slot_bus_if.sv
design/step_decoder.sv
design/save_policy.sv
design/operand_slot.sv
design/bus_mux.sv
design/mem_manager.sv
verif/tb_mem_manager.sv
